/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // full product of a 32x32 multiply
    typedef struct packed {
        word_t hi;
        word_t lo;
    } dword_t;

    typedef enum logic [5:0] {
        OP_NOP,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOR,
        OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
        OP_LUI, OP_MOVN, OP_MOVZ,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU, OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU,
        OP_MUL, OP_MULT, OP_MULTU,
        OP_JALR, OP_JAL, OP_BLTZAL, OP_BGEZAL,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW,
        OP_MTC0, OP_MFC0
    } oper_t;

    typedef struct packed {
        oper_t     oper;
        word_t     pc;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wreg_addr;
        logic      wreg_write;
    } issue_t;

    typedef struct packed {
        oper_t     oper;
        logic      wreg_write;
        reg_addr_t wreg_addr;
        word_t     wreg_data;
        logic      whilo;
        word_t     hi;
        word_t     lo;
        word_t     mem_addr;
        word_t     mem_data;
        logic      cp0_we;
        reg_addr_t cp0_addr;
        word_t     cp0_data;
    } ex_out_t;

    typedef struct packed {
        logic  we;
        word_t hi;
        word_t lo;
    } hilo_fwd_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } cp0_fwd_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } wb_out_t;

endpackage

`default_nettype wire

/* verilog/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // master side of a classic cycle
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // slave side
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* verilog/ex.sv */
`timescale 1ns/1ns
`default_nettype none

module ex (
    input  cpu_pkg::issue_t    issue_i,
    input  cpu_pkg::hilo_fwd_t mem_hilo_i,
    input  cpu_pkg::hilo_fwd_t wb_hilo_i,
    input  cpu_pkg::word_t     hi_i,
    input  cpu_pkg::word_t     lo_i,
    input  cpu_pkg::cp0_fwd_t  mem_cp0_i,
    input  cpu_pkg::cp0_fwd_t  wb_cp0_i,
    input  cpu_pkg::word_t     cp0_data_i,
    output cpu_pkg::reg_addr_t cp0_raddr_o,
    output cpu_pkg::ex_out_t   ex_o
);

    cpu_pkg::word_t     reg1;
    cpu_pkg::word_t     reg2;
    cpu_pkg::word_t     hi;
    cpu_pkg::word_t     lo;
    cpu_pkg::word_t     cp0_data;
    cpu_pkg::reg_addr_t cp0_sel;

    assign reg1 = issue_i.reg1;
    assign reg2 = issue_i.reg2;

    // newest hi/lo wins: memory stage, then writeback, then the registers
    always_comb begin
        if (mem_hilo_i.we) begin
            {hi, lo} = {mem_hilo_i.hi, mem_hilo_i.lo};
        end else if (wb_hilo_i.we) begin
            {hi, lo} = {wb_hilo_i.hi, wb_hilo_i.lo};
        end else begin
            {hi, lo} = {hi_i, lo_i};
        end
    end

    // cp0 register number sits in the low bits of operand 2
    assign cp0_sel     = reg2[4:0];
    assign cp0_raddr_o = cp0_sel;

    always_comb begin
        if (mem_cp0_i.we && mem_cp0_i.addr == cp0_sel) begin
            cp0_data = mem_cp0_i.data;
        end else if (wb_cp0_i.we && wb_cp0_i.addr == cp0_sel) begin
            cp0_data = wb_cp0_i.data;
        end else begin
            cp0_data = cp0_data_i;
        end
    end

    cpu_pkg::word_t add_u;
    cpu_pkg::word_t sub_u;
    logic           signed_lt;
    logic           unsigned_lt;

    assign add_u       = reg1 + reg2;
    assign sub_u       = reg1 - reg2;
    assign signed_lt   = (reg1[31] != reg2[31]) ? reg1[31] : sub_u[31];
    assign unsigned_lt = (reg1 < reg2);

    // multiply on magnitudes, sign restored afterwards
    logic            is_signed;
    logic            res_sign;
    cpu_pkg::word_t  abs_reg1;
    cpu_pkg::word_t  abs_reg2;
    logic [63:0]     mul_abs;
    cpu_pkg::dword_t mul_res;

    assign is_signed = (issue_i.oper != cpu_pkg::OP_MULTU);
    assign res_sign  = is_signed && (reg1[31] ^ reg2[31]);
    assign abs_reg1  = (is_signed && reg1[31]) ? -reg1 : reg1;
    assign abs_reg2  = (is_signed && reg2[31]) ? -reg2 : reg2;
    assign mul_abs   = {32'b0, abs_reg1} * {32'b0, abs_reg2};
    assign mul_res   = res_sign ? -mul_abs : mul_abs;

    always_comb begin
        ex_o            = '0;
        ex_o.oper       = issue_i.oper;
        ex_o.wreg_write = issue_i.wreg_write;
        ex_o.wreg_addr  = issue_i.wreg_addr;
        ex_o.hi         = hi;
        ex_o.lo         = lo;

        case (issue_i.oper)
            cpu_pkg::OP_AND, cpu_pkg::OP_ANDI: ex_o.wreg_data = reg1 & reg2;
            cpu_pkg::OP_OR, cpu_pkg::OP_ORI:   ex_o.wreg_data = reg1 | reg2;
            cpu_pkg::OP_XOR, cpu_pkg::OP_XORI: ex_o.wreg_data = reg1 ^ reg2;
            cpu_pkg::OP_NOR:                   ex_o.wreg_data = ~(reg1 | reg2);
            cpu_pkg::OP_SLL, cpu_pkg::OP_SLLV: ex_o.wreg_data = reg2 << reg1[4:0];
            cpu_pkg::OP_SRL, cpu_pkg::OP_SRLV: ex_o.wreg_data = reg2 >> reg1[4:0];
            cpu_pkg::OP_SRA, cpu_pkg::OP_SRAV: ex_o.wreg_data = $signed(reg2) >>> reg1[4:0];
            cpu_pkg::OP_LUI:                   ex_o.wreg_data = {reg2[15:0], 16'b0};
            cpu_pkg::OP_MOVN: begin
                ex_o.wreg_data  = reg1;
                ex_o.wreg_write = issue_i.wreg_write && (reg2 != '0);
            end
            cpu_pkg::OP_MOVZ: begin
                ex_o.wreg_data  = reg1;
                ex_o.wreg_write = issue_i.wreg_write && (reg2 == '0);
            end
            cpu_pkg::OP_MFHI: ex_o.wreg_data = hi;
            cpu_pkg::OP_MFLO: ex_o.wreg_data = lo;
            cpu_pkg::OP_MTHI, cpu_pkg::OP_MTLO, cpu_pkg::OP_MULT, cpu_pkg::OP_MULTU: begin
                ex_o.whilo      = 1'b1;
                ex_o.wreg_write = 1'b0;
                ex_o.wreg_addr  = '0;
                if (issue_i.oper == cpu_pkg::OP_MTHI) begin
                    ex_o.hi = reg1;
                end else if (issue_i.oper == cpu_pkg::OP_MTLO) begin
                    ex_o.lo = reg1;
                end else begin
                    {ex_o.hi, ex_o.lo} = mul_res;
                end
            end
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI, cpu_pkg::OP_ADDU, cpu_pkg::OP_ADDIU:
                ex_o.wreg_data = add_u;
            cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU: ex_o.wreg_data = sub_u;
            cpu_pkg::OP_SLT, cpu_pkg::OP_SLTI: ex_o.wreg_data = {31'b0, signed_lt};
            cpu_pkg::OP_SLTU, cpu_pkg::OP_SLTIU: ex_o.wreg_data = {31'b0, unsigned_lt};
            cpu_pkg::OP_MUL:  ex_o.wreg_data = mul_res.lo;
            cpu_pkg::OP_JALR: ex_o.wreg_data = issue_i.pc + 32'd8;
            cpu_pkg::OP_JAL, cpu_pkg::OP_BLTZAL, cpu_pkg::OP_BGEZAL: begin
                ex_o.wreg_write = 1'b1;
                ex_o.wreg_data  = issue_i.pc + 32'd8;
            end
            cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_LH, cpu_pkg::OP_LHU, cpu_pkg::OP_LW:
                ex_o.mem_addr = add_u;
            cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW: begin
                // stores carry no register result
                ex_o.wreg_write = 1'b0;
                ex_o.mem_addr   = reg1;
                ex_o.mem_data   = reg2;
            end
            cpu_pkg::OP_MTC0: begin
                ex_o.cp0_we   = 1'b1;
                ex_o.cp0_addr = cp0_sel;
                ex_o.cp0_data = reg1;
            end
            cpu_pkg::OP_MFC0: ex_o.wreg_data = cp0_data;
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               accept_i,
    input  cpu_pkg::ex_out_t   ex_i,
    output wb_pkg::wb_req_t    bus_o,
    input  wb_pkg::wb_rsp_t    bus_i,
    output logic               stall_o,
    output cpu_pkg::hilo_fwd_t mem_hilo_o,
    output cpu_pkg::hilo_fwd_t wb_hilo_o,
    output cpu_pkg::cp0_fwd_t  mem_cp0_o,
    output cpu_pkg::cp0_fwd_t  wb_cp0_o,
    output cpu_pkg::wb_out_t   wb_o
);

    logic             mem_valid;
    logic             wb_valid;
    cpu_pkg::ex_out_t mem_q;
    cpu_pkg::ex_out_t wb_q;
    logic             is_load;
    logic             is_store;
    logic             mem_pending;
    logic             mem_done;

    // sub-word accesses are handled as full words
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (mem_q.oper)
            cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_LH, cpu_pkg::OP_LHU, cpu_pkg::OP_LW:
                is_load = 1'b1;
            cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW:
                is_store = 1'b1;
            default: begin
            end
        endcase
    end

    assign mem_pending = mem_valid && (is_load || is_store);
    assign mem_done    = mem_valid && (!(is_load || is_store) || bus_i.ack);
    assign stall_o     = mem_pending && !bus_i.ack;

    // request held stable until the acking edge
    assign bus_o.cyc = mem_pending;
    assign bus_o.stb = mem_pending;
    assign bus_o.we  = mem_pending && is_store;
    assign bus_o.adr = mem_q.mem_addr;
    assign bus_o.dat = mem_q.mem_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (accept_i) begin
                mem_valid <= 1'b1;
            end else if (mem_done) begin
                mem_valid <= 1'b0;
            end
            wb_valid <= mem_done;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            mem_q <= ex_i;
        end
        if (mem_done) begin
            wb_q <= mem_q;
            // load data takes the place of the register result
            if (is_load) begin
                wb_q.wreg_data <= bus_i.dat;
            end
        end
    end

    assign mem_hilo_o = '{we: mem_valid && mem_q.whilo, hi: mem_q.hi, lo: mem_q.lo};
    assign wb_hilo_o  = '{we: wb_valid && wb_q.whilo, hi: wb_q.hi, lo: wb_q.lo};

    assign mem_cp0_o = '{we: mem_valid && mem_q.cp0_we, addr: mem_q.cp0_addr,
                         data: mem_q.cp0_data};
    assign wb_cp0_o  = '{we: wb_valid && wb_q.cp0_we, addr: wb_q.cp0_addr,
                         data: wb_q.cp0_data};

    assign wb_o = '{valid: wb_valid && wb_q.wreg_write, addr: wb_q.wreg_addr,
                    data: wb_q.wreg_data};

endmodule

`default_nettype wire

/* verilog/special_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module special_regs #(
    parameter int cp0_regs = 8
) (
    input  logic               clk,
    input  logic               reset_i,
    input  cpu_pkg::hilo_fwd_t hilo_i,
    input  cpu_pkg::cp0_fwd_t  cp0_i,
    input  cpu_pkg::reg_addr_t cp0_raddr_i,
    output cpu_pkg::word_t     hi_o,
    output cpu_pkg::word_t     lo_o,
    output cpu_pkg::word_t     cp0_data_o
);

    localparam int idx_w = $clog2(cp0_regs);

    cpu_pkg::word_t hi_q;
    cpu_pkg::word_t lo_q;
    cpu_pkg::word_t cp0_q [cp0_regs];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (hilo_i.we) begin
            hi_q <= hilo_i.hi;
            lo_q <= hilo_i.lo;
        end
    end

    // upper register-number bits fold onto the implemented set
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < cp0_regs; i++) begin
                cp0_q[i] <= '0;
            end
        end else if (cp0_i.we) begin
            cp0_q[cp0_i.addr[idx_w-1:0]] <= cp0_i.data;
        end
    end

    assign hi_o       = hi_q;
    assign lo_o       = lo_q;
    assign cp0_data_o = cp0_q[cp0_raddr_i[idx_w-1:0]];

endmodule

`default_nettype wire

/* verilog/wb_data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_data_ram #(
    parameter int ram_words = 256
) (
    input  logic            clk,
    input  logic            reset_i,
    input  wb_pkg::wb_req_t bus_i,
    output wb_pkg::wb_rsp_t bus_o
);

    localparam int aw = $clog2(ram_words);

    logic [31:0] mem [ram_words];
    logic [31:0] rdata_q;
    logic        ack_q;
    logic [aw-1:0] idx;

    // byte address, word granularity
    assign idx = bus_i.adr[aw+1:2];

    // one ack per strobe, then idle for a cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_i.cyc && bus_i.stb && !ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_i.cyc && bus_i.stb && !ack_q) begin
            rdata_q <= mem[idx];
        end
        if (ack_q && bus_i.we) begin
            mem[idx] <= bus_i.dat;
        end
    end

    assign bus_o.ack = ack_q;
    assign bus_o.dat = rdata_q;

endmodule

`default_nettype wire

/* verilog/ex_backend.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_backend #(
    parameter int ram_words = 256,
    parameter int cp0_regs  = 8
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             issue_valid_i,
    input  cpu_pkg::issue_t  issue_i,
    output logic             stall_o,
    output cpu_pkg::wb_out_t wb_o
);

    logic               accept;
    cpu_pkg::ex_out_t   ex_out;
    cpu_pkg::hilo_fwd_t mem_hilo;
    cpu_pkg::hilo_fwd_t wb_hilo;
    cpu_pkg::cp0_fwd_t  mem_cp0;
    cpu_pkg::cp0_fwd_t  wb_cp0;
    cpu_pkg::word_t     hi;
    cpu_pkg::word_t     lo;
    cpu_pkg::word_t     cp0_data;
    cpu_pkg::reg_addr_t cp0_raddr;
    wb_pkg::wb_req_t    bus_req;
    wb_pkg::wb_rsp_t    bus_rsp;

    // issuer holds its bundle while stalled
    assign accept = issue_valid_i && !stall_o;

    ex u_ex (
        .issue_i     (issue_i),
        .mem_hilo_i  (mem_hilo),
        .wb_hilo_i   (wb_hilo),
        .hi_i        (hi),
        .lo_i        (lo),
        .mem_cp0_i   (mem_cp0),
        .wb_cp0_i    (wb_cp0),
        .cp0_data_i  (cp0_data),
        .cp0_raddr_o (cp0_raddr),
        .ex_o        (ex_out)
    );

    mem_stage u_mem_stage (
        .clk        (clk),
        .reset_i    (reset_i),
        .accept_i   (accept),
        .ex_i       (ex_out),
        .bus_o      (bus_req),
        .bus_i      (bus_rsp),
        .stall_o    (stall_o),
        .mem_hilo_o (mem_hilo),
        .wb_hilo_o  (wb_hilo),
        .mem_cp0_o  (mem_cp0),
        .wb_cp0_o   (wb_cp0),
        .wb_o       (wb_o)
    );

    special_regs #(
        .cp0_regs (cp0_regs)
    ) u_special_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .hilo_i      (wb_hilo),
        .cp0_i       (wb_cp0),
        .cp0_raddr_i (cp0_raddr),
        .hi_o        (hi),
        .lo_o        (lo),
        .cp0_data_o  (cp0_data)
    );

    wb_data_ram #(
        .ram_words (ram_words)
    ) u_wb_data_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .bus_i   (bus_req),
        .bus_o   (bus_rsp)
    );

endmodule

`default_nettype wire

/* dv/tb_ex_backend.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ex_backend;

    // one table entry: issued bundle plus the expected register write
    typedef struct packed {
        cpu_pkg::issue_t iss;
        logic            exp_write;
        cpu_pkg::word_t  exp_data;
        logic            is_mem;
    } row_t;

    logic             clk;
    logic             reset_i;
    logic             issue_valid_i;
    cpu_pkg::issue_t  issue_i;
    logic             stall_o;
    cpu_pkg::wb_out_t wb_o;

    row_t             rows[$];
    cpu_pkg::wb_out_t got[$];
    integer           seed;
    int               errors;
    int               passed;
    logic             prev_mem;

    // architectural state of the reference, updated in issue order
    cpu_pkg::word_t   ref_hi;
    cpu_pkg::word_t   ref_lo;
    cpu_pkg::word_t   ref_cp0 [8];
    cpu_pkg::word_t   ref_mem [int];

    ex_backend u_ex_backend (
        .clk           (clk),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .stall_o       (stall_o),
        .wb_o          (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // collect every committed write, sampled away from the rising edge
    always @(negedge clk) begin
        if (!reset_i && wb_o.valid) begin
            got.push_back(wb_o);
        end
    end

    function automatic row_t predict(cpu_pkg::issue_t iss);
        row_t           r;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t addr;
        logic [63:0]    prod;
        a           = iss.reg1;
        b           = iss.reg2;
        r           = '0;
        r.iss       = iss;
        r.exp_write = iss.wreg_write;
        prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (iss.oper)
            cpu_pkg::OP_AND:  r.exp_data = a & b;
            cpu_pkg::OP_OR:   r.exp_data = a | b;
            cpu_pkg::OP_XOR:  r.exp_data = a ^ b;
            cpu_pkg::OP_NOR:  r.exp_data = ~(a | b);
            cpu_pkg::OP_SLL:  r.exp_data = b << a[4:0];
            cpu_pkg::OP_SRL:  r.exp_data = b >> a[4:0];
            cpu_pkg::OP_SRA:  r.exp_data = $signed(b) >>> a[4:0];
            cpu_pkg::OP_LUI:  r.exp_data = {b[15:0], 16'h0};
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADDU: r.exp_data = a + b;
            cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU: r.exp_data = a - b;
            cpu_pkg::OP_SLT:  r.exp_data = {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::OP_SLTU: r.exp_data = {31'b0, a < b};
            cpu_pkg::OP_MOVN: begin
                r.exp_data  = a;
                r.exp_write = iss.wreg_write && (b != 32'h0);
            end
            cpu_pkg::OP_MOVZ: begin
                r.exp_data  = a;
                r.exp_write = iss.wreg_write && (b == 32'h0);
            end
            cpu_pkg::OP_MFHI: r.exp_data = ref_hi;
            cpu_pkg::OP_MFLO: r.exp_data = ref_lo;
            cpu_pkg::OP_MTHI: begin
                ref_hi      = a;
                r.exp_write = 1'b0;
            end
            cpu_pkg::OP_MTLO: begin
                ref_lo      = a;
                r.exp_write = 1'b0;
            end
            cpu_pkg::OP_MULT: begin
                {ref_hi, ref_lo} = prod;
                r.exp_write      = 1'b0;
            end
            cpu_pkg::OP_MULTU: begin
                {ref_hi, ref_lo} = {32'h0, a} * {32'h0, b};
                r.exp_write      = 1'b0;
            end
            cpu_pkg::OP_MUL:  r.exp_data = prod[31:0];
            cpu_pkg::OP_JALR: r.exp_data = iss.pc + 32'd8;
            cpu_pkg::OP_JAL: begin
                r.exp_data  = iss.pc + 32'd8;
                r.exp_write = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                addr       = a + b;
                r.is_mem   = 1'b1;
                r.exp_data = ref_mem[int'(addr[9:2])];
            end
            cpu_pkg::OP_SW: begin
                r.is_mem                 = 1'b1;
                r.exp_write              = 1'b0;
                ref_mem[int'(a[9:2])]    = b;
            end
            cpu_pkg::OP_MTC0: ref_cp0[b[2:0]] = a;
            cpu_pkg::OP_MFC0: r.exp_data = ref_cp0[b[2:0]];
            default: begin
            end
        endcase
        return r;
    endfunction

    task automatic add_row(cpu_pkg::oper_t op, cpu_pkg::word_t pc, cpu_pkg::word_t a,
                           cpu_pkg::word_t b, cpu_pkg::reg_addr_t waddr, logic wr);
        cpu_pkg::issue_t iss;
        iss.oper       = op;
        iss.pc         = pc;
        iss.reg1       = a;
        iss.reg2       = b;
        iss.wreg_addr  = waddr;
        iss.wreg_write = wr;
        rows.push_back(predict(iss));
    endtask

    task automatic build_table();
        cpu_pkg::oper_t rand_ops [13];
        cpu_pkg::word_t ra;
        cpu_pkg::word_t rb;
        cpu_pkg::word_t rd;
        rand_ops = '{cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_NOR,
                     cpu_pkg::OP_SLL, cpu_pkg::OP_SRL, cpu_pkg::OP_SRA, cpu_pkg::OP_ADD,
                     cpu_pkg::OP_ADDU, cpu_pkg::OP_SUB, cpu_pkg::OP_SLT, cpu_pkg::OP_SLTU,
                     cpu_pkg::OP_LUI};
        // reset values first
        add_row(cpu_pkg::OP_MFHI, 32'h0, 32'h0, 32'h0, 5'd1, 1'b1);
        add_row(cpu_pkg::OP_MFLO, 32'h0, 32'h0, 32'h0, 5'd2, 1'b1);
        add_row(cpu_pkg::OP_MFC0, 32'h0, 32'h0, 32'h3, 5'd3, 1'b1);
        // products read back to back
        add_row(cpu_pkg::OP_MULT, 32'h0, 32'hffff_fffd, 32'h7, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_MFHI, 32'h0, 32'h0, 32'h0, 5'd4, 1'b1);
        add_row(cpu_pkg::OP_MFLO, 32'h0, 32'h0, 32'h0, 5'd5, 1'b1);
        add_row(cpu_pkg::OP_MULTU, 32'h0, 32'hffff_ffff, 32'h2, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_MFLO, 32'h0, 32'h0, 32'h0, 5'd6, 1'b1);
        add_row(cpu_pkg::OP_MFHI, 32'h0, 32'h0, 32'h0, 5'd7, 1'b1);
        // two hi writes in flight, the newer one must win
        add_row(cpu_pkg::OP_MTLO, 32'h0, 32'h9abc_def0, 32'h0, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_MTHI, 32'h0, 32'h0bad_cafe, 32'h0, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_MTHI, 32'h0, 32'h1234_5678, 32'h0, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_MFHI, 32'h0, 32'h0, 32'h0, 5'd8, 1'b1);
        add_row(cpu_pkg::OP_MFLO, 32'h0, 32'h0, 32'h0, 5'd9, 1'b1);
        add_row(cpu_pkg::OP_MUL, 32'h0, 32'hffff_fffb, 32'h6, 5'd10, 1'b1);
        // conditional moves and links
        add_row(cpu_pkg::OP_MOVN, 32'h0, 32'h55, 32'h1, 5'd11, 1'b1);
        add_row(cpu_pkg::OP_MOVN, 32'h0, 32'h66, 32'h0, 5'd12, 1'b1);
        add_row(cpu_pkg::OP_MOVZ, 32'h0, 32'h77, 32'h0, 5'd13, 1'b1);
        add_row(cpu_pkg::OP_MOVZ, 32'h0, 32'h88, 32'h9, 5'd14, 1'b1);
        add_row(cpu_pkg::OP_JAL, 32'h400, 32'h0, 32'h0, 5'd31, 1'b1);
        add_row(cpu_pkg::OP_JALR, 32'h1000, 32'h0, 32'h0, 5'd15, 1'b1);
        // memory traffic, each issue right behind the last
        add_row(cpu_pkg::OP_SW, 32'h0, 32'h40, 32'hdead_beef, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_LW, 32'h0, 32'h3c, 32'h4, 5'd16, 1'b1);
        add_row(cpu_pkg::OP_ADD, 32'h0, 32'h1, 32'h2, 5'd17, 1'b1);
        add_row(cpu_pkg::OP_SW, 32'h0, 32'h80, 32'h0bad_f00d, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_SW, 32'h0, 32'h84, 32'h1122_3344, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_LW, 32'h0, 32'h80, 32'h0, 5'd18, 1'b1);
        add_row(cpu_pkg::OP_LW, 32'h0, 32'h84, 32'h0, 5'd19, 1'b1);
        // cp0 through mem, writeback and the register array
        add_row(cpu_pkg::OP_MTC0, 32'h0, 32'ha5a5, 32'h3, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_MFC0, 32'h0, 32'h0, 32'h3, 5'd20, 1'b1);
        add_row(cpu_pkg::OP_MTC0, 32'h0, 32'h1234, 32'h5, 5'd0, 1'b0);
        // write to another cp0 register sits in the memory stage
        add_row(cpu_pkg::OP_MFC0, 32'h0, 32'h0, 32'h3, 5'd24, 1'b1);
        add_row(cpu_pkg::OP_MFC0, 32'h0, 32'h0, 32'h5, 5'd21, 1'b1);
        add_row(cpu_pkg::OP_NOP, 32'h0, 32'h0, 32'h0, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_NOP, 32'h0, 32'h0, 32'h0, 5'd0, 1'b0);
        add_row(cpu_pkg::OP_MFC0, 32'h0, 32'h0, 32'h5, 5'd22, 1'b1);
        add_row(cpu_pkg::OP_MFC0, 32'h0, 32'h0, 32'h3, 5'd23, 1'b1);
        for (int i = 0; i < 26; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            rd = $random(seed);
            add_row(rand_ops[i % 13], 32'h0, ra, rb, rd[4:0], 1'b1);
        end
    endtask

    task automatic check_stall_rose();
        if (prev_mem && !stall_o) begin
            $display("** Error at %0t: stall_o low right after a memory issue", $time);
            errors++;
        end
    endtask

    task automatic present_row(row_t r);
        int waited;
        waited = 0;
        @(negedge clk);
        check_stall_rose();
        issue_valid_i = 1'b1;
        issue_i       = r.iss;
        // hold the bundle until stall_o drops
        while (stall_o && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (stall_o) begin
            $display("timeout: stall_o stayed high and the issue was never accepted");
            errors++;
        end
        @(posedge clk);
        prev_mem = r.is_mem;
    endtask

    task automatic drive_rows();
        for (int i = 0; i < rows.size(); i++) begin
            present_row(rows[i]);
        end
        @(negedge clk);
        check_stall_rose();
        issue_valid_i = 1'b0;
    endtask

    task automatic check_rows();
        cpu_pkg::wb_out_t w;
        cpu_pkg::oper_t   op;
        int               waited;
        for (int i = 0; i < rows.size(); i++) begin
            op = rows[i].iss.oper;
            if (!rows[i].exp_write) begin
                passed++;
                $display("row %0d %s: no register write expected", i, op.name());
            end else begin
                waited = 0;
                // polled on the rising edge, half a cycle after collection
                while (got.size() == 0 && waited < 100) begin
                    @(posedge clk);
                    waited++;
                end
                if (got.size() == 0) begin
                    $display("row %0d %s: timeout, no register write arrived", i, op.name());
                    errors++;
                end else begin
                    w = got.pop_front();
                    if (w.addr !== rows[i].iss.wreg_addr || w.data !== rows[i].exp_data) begin
                        $display("** Error at %0t: row %0d %s got r%0d=%h, expected r%0d=%h",
                                 $time, i, op.name(), w.addr, w.data,
                                 rows[i].iss.wreg_addr, rows[i].exp_data);
                        errors++;
                    end else begin
                        passed++;
                        $display("row %0d %s: ok, r%0d=%h", i, op.name(), w.addr, w.data);
                    end
                end
            end
        end
    endtask

    initial begin
        seed          = 32'hcbd8;
        errors        = 0;
        passed        = 0;
        prev_mem      = 1'b0;
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        ref_hi        = '0;
        ref_lo        = '0;
        for (int i = 0; i < 8; i++) begin
            ref_cp0[i] = '0;
        end
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        fork
            drive_rows();
            check_rows();
        join
        // anything left over is a write nobody asked for
        repeat (10) @(negedge clk);
        if (got.size() != 0) begin
            $display("extra register writes seen on wb_o: %0d", got.size());
            errors++;
        end
        $display("rows passed: %0d, errors: %0d", passed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/cpu_pkg.sv
verilog/wb_pkg.sv
verilog/ex.sv
verilog/mem_stage.sv
verilog/special_regs.sv
verilog/wb_data_ram.sv
verilog/ex_backend.sv
dv/tb_ex_backend.sv

/* Bender.yml */
package:
  name: ex_backend

sources:
  - verilog/cpu_pkg.sv
  - verilog/wb_pkg.sv
  - verilog/ex.sv
  - verilog/mem_stage.sv
  - verilog/special_regs.sv
  - verilog/wb_data_ram.sv
  - verilog/ex_backend.sv
  - target: test
    files:
      - dv/tb_ex_backend.sv
